/* design/rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0;

    // base opcodes of the supported subset
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc_plus4
    } result_src_t;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_from_m,
        fwd_from_w
    } fwd_sel_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc_plus4;
    } if_id_t;

    // all-zero value is a bubble: no register or memory write
    typedef struct packed {
        logic                  reg_write;
        result_src_t           result_src;
        logic                  mem_read;
        logic                  mem_write;
        logic                  branch;
        logic                  branch_ne;
        logic                  jump;
        logic                  jalr;
        alu_op_t               alu_op;
        logic                  alu_src_imm;
        logic [xlen-1:0]       rd1;
        logic [xlen-1:0]       rd2;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       pc_plus4;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        result_src_t           result_src;
        logic                  mem_read;
        logic                  mem_write;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       write_data;
        logic [xlen-1:0]       pc_plus4;
        logic [reg_addr_w-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        result_src_t           result_src;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       read_data;
        logic [xlen-1:0]       pc_plus4;
        logic [reg_addr_w-1:0] rd;
    } mem_wb_t;

endpackage

/* design/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush beats stall, zero payload is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic [rv_pkg::reg_addr_w-1:0] ra1,
    input  logic [rv_pkg::reg_addr_w-1:0] ra2,
    output logic [rv_pkg::xlen-1:0]       rd1,
    output logic [rv_pkg::xlen-1:0]       rd2,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] wa,
    input  logic [rv_pkg::xlen-1:0]       wd
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // same-cycle write is visible to the reader
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                          clk,
    input  rv_pkg::if_id_t                if_id,
    output rv_pkg::id_ex_t                id_ex,
    input  logic                          wb_we,
    input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_pkg::xlen-1:0]       wb_data,
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2
);
    import rv_pkg::*;

    logic [xlen-1:0] instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_u;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    reg_file u_reg_file (
        .clk (clk),
        .ra1 (rs1),
        .ra2 (rs2),
        .rd1 (rd1),
        .rd2 (rd2),
        .we  (wb_we),
        .wa  (wb_rd),
        .wd  (wb_data)
    );

    always_comb begin
        id_ex          = '0;
        id_ex.rd1      = rd1;
        id_ex.rd2      = rd2;
        id_ex.pc       = if_id.pc;
        id_ex.pc_plus4 = if_id.pc_plus4;
        id_ex.rs1      = rs1;
        id_ex.rs2      = rs2;
        id_ex.rd       = instr[11:7];
        case (opcode)
            op_rtype: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_op    = alu_sel(funct3, instr[30]);
            end
            op_itype: begin
                id_ex.reg_write   = 1'b1;
                id_ex.alu_src_imm = 1'b1;
                id_ex.alu_op      = alu_sel(funct3, 1'b0);
                id_ex.imm         = imm_i;
            end
            op_load: begin
                id_ex.reg_write   = 1'b1;
                id_ex.result_src  = res_mem;
                id_ex.mem_read    = 1'b1;
                id_ex.alu_src_imm = 1'b1;
                id_ex.imm         = imm_i;
            end
            op_store: begin
                id_ex.mem_write   = 1'b1;
                id_ex.alu_src_imm = 1'b1;
                id_ex.imm         = imm_s;
            end
            op_branch: begin
                id_ex.branch    = 1'b1;
                // funct3 bit 0 separates bne from beq
                id_ex.branch_ne = funct3[0];
                id_ex.imm       = imm_b;
            end
            op_jal: begin
                id_ex.reg_write  = 1'b1;
                id_ex.result_src = res_pc_plus4;
                id_ex.jump       = 1'b1;
                id_ex.imm        = imm_j;
            end
            op_jalr: begin
                id_ex.reg_write  = 1'b1;
                id_ex.result_src = res_pc_plus4;
                id_ex.jump       = 1'b1;
                id_ex.jalr       = 1'b1;
                id_ex.imm        = imm_i;
            end
            op_lui: begin
                id_ex.reg_write   = 1'b1;
                id_ex.alu_src_imm = 1'b1;
                id_ex.alu_op      = alu_pass_b;
                id_ex.imm         = imm_u;
            end
            default: begin
                // unknown opcode leaves the control fields at zero
                id_ex.rd = '0;
            end
        endcase
    end

endmodule

/* design/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
    input  rv_pkg::id_ex_t          id_ex,
    input  rv_pkg::fwd_sel_t        fwd_a,
    input  rv_pkg::fwd_sel_t        fwd_b,
    input  logic [rv_pkg::xlen-1:0] m_value,
    input  logic [rv_pkg::xlen-1:0] w_value,
    output rv_pkg::ex_mem_t         ex_mem,
    output logic                    pc_src,
    output logic [rv_pkg::xlen-1:0] pc_target
);
    import rv_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] fwd_b_val;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] jalr_sum;
    logic            equal;

    always_comb begin
        case (fwd_a)
            fwd_from_m: src_a = m_value;
            fwd_from_w: src_a = w_value;
            default:    src_a = id_ex.rd1;
        endcase
        case (fwd_b)
            fwd_from_m: fwd_b_val = m_value;
            fwd_from_w: fwd_b_val = w_value;
            default:    fwd_b_val = id_ex.rd2;
        endcase
    end

    assign src_b = id_ex.alu_src_imm ? id_ex.imm : fwd_b_val;

    always_comb begin
        case (id_ex.alu_op)
            alu_sub:    alu_result = src_a - src_b;
            alu_and:    alu_result = src_a & src_b;
            alu_or:     alu_result = src_a | src_b;
            alu_xor:    alu_result = src_a ^ src_b;
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            alu_pass_b: alu_result = src_b;
            default:    alu_result = src_a + src_b;
        endcase
    end

    // branch compare on the forwarded register values
    assign equal    = (src_a == fwd_b_val);
    assign pc_src   = id_ex.jump | (id_ex.branch & (equal ^ id_ex.branch_ne));
    assign jalr_sum = src_a + id_ex.imm;
    assign pc_target = id_ex.jalr ? {jalr_sum[xlen-1:1], 1'b0} : id_ex.pc + id_ex.imm;

    always_comb begin
        ex_mem.reg_write  = id_ex.reg_write;
        ex_mem.result_src = id_ex.result_src;
        ex_mem.mem_read   = id_ex.mem_read;
        ex_mem.mem_write  = id_ex.mem_write;
        ex_mem.alu_result = alu_result;
        ex_mem.write_data = fwd_b_val;
        ex_mem.pc_plus4   = id_ex.pc_plus4;
        ex_mem.rd         = id_ex.rd;
    end

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_d,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_d,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_e,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_e,
    input  logic [rv_pkg::reg_addr_w-1:0] rd_e,
    input  logic                          mem_read_e,
    input  logic                          pc_src,
    input  logic [rv_pkg::reg_addr_w-1:0] rd_m,
    input  logic                          reg_write_m,
    input  logic [rv_pkg::reg_addr_w-1:0] rd_w,
    input  logic                          reg_write_w,
    input  logic                          mem_access_m,
    input  logic                          data_valid,
    output logic                          stall_f,
    output logic                          stall_d,
    output logic                          stall_e,
    output logic                          stall_m,
    output logic                          stall_w,
    output logic                          flush_d,
    output logic                          flush_e,
    output rv_pkg::fwd_sel_t              fwd_a,
    output rv_pkg::fwd_sel_t              fwd_b
);
    import rv_pkg::*;

    logic mem_wait;
    logic lw_stall;

    assign mem_wait = mem_access_m & ~data_valid;
    assign lw_stall = mem_read_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

    // a pending data access freezes every stage
    assign stall_f = mem_wait | lw_stall;
    assign stall_d = mem_wait | lw_stall;
    assign stall_e = mem_wait;
    assign stall_m = mem_wait;
    assign stall_w = mem_wait;

    // no flush while frozen, else the held branch or load would be lost
    assign flush_d = pc_src & ~mem_wait;
    assign flush_e = (pc_src | lw_stall) & ~mem_wait;

    assign fwd_a = (reg_write_m && rd_m != '0 && rd_m == rs1_e) ? fwd_from_m :
                   (reg_write_w && rd_w != '0 && rd_w == rs1_e) ? fwd_from_w : fwd_reg;
    assign fwd_b = (reg_write_m && rd_m != '0 && rd_m == rs2_e) ? fwd_from_m :
                   (reg_write_w && rd_w != '0 && rd_w == rs2_e) ? fwd_from_w : fwd_reg;

endmodule

/* design/riscv_pipeline.sv */
`timescale 1ns/1ps

module riscv_pipeline (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic                    instr_en,
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] data_addr,
    output logic [rv_pkg::xlen-1:0] data_wdata,
    output logic                    data_re,
    output logic                    data_we,
    input  logic [rv_pkg::xlen-1:0] data_rdata,
    input  logic                    data_valid
);
    import rv_pkg::*;

    if_id_t  if_id_d, if_id_q;
    id_ex_t  id_ex_d, id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    logic                  stall_f, stall_d, stall_e, stall_m, stall_w;
    logic                  flush_d, flush_e;
    fwd_sel_t              fwd_a, fwd_b;
    logic                  pc_src;
    logic [xlen-1:0]       pc_target;
    logic [xlen-1:0]       pc_plus4;
    logic [reg_addr_w-1:0] rs1_d, rs2_d;
    logic [xlen-1:0]       m_value;
    logic [xlen-1:0]       result_w;
    logic                  wb_we;

    // fetch
    assign pc_plus4 = pc + 32'd4;
    assign instr_en = ~stall_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (!stall_f) begin
            pc <= pc_src ? pc_target : pc_plus4;
        end
    end

    always_comb begin
        if_id_d.pc       = pc;
        if_id_d.instr    = instr;
        if_id_d.pc_plus4 = pc_plus4;
    end

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk   (clk),
        .rst   (rst),
        .stall (stall_d),
        .flush (flush_d),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    decode_stage u_decode_stage (
        .clk     (clk),
        .if_id   (if_id_q),
        .id_ex   (id_ex_d),
        .wb_we   (wb_we),
        .wb_rd   (mem_wb_q.rd),
        .wb_data (result_w),
        .rs1     (rs1_d),
        .rs2     (rs2_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst   (rst),
        .stall (stall_e),
        .flush (flush_e),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // jal/jalr in memory forward their link value
    assign m_value = (ex_mem_q.result_src == res_pc_plus4) ? ex_mem_q.pc_plus4
                                                           : ex_mem_q.alu_result;

    exec_stage u_exec_stage (
        .id_ex     (id_ex_q),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .m_value   (m_value),
        .w_value   (result_w),
        .ex_mem    (ex_mem_d),
        .pc_src    (pc_src),
        .pc_target (pc_target)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .rst   (rst),
        .stall (stall_m),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // memory port straight from ex/mem, held steady while frozen
    assign data_addr  = ex_mem_q.alu_result;
    assign data_wdata = ex_mem_q.write_data;
    assign data_re    = ex_mem_q.mem_read;
    assign data_we    = ex_mem_q.mem_write;

    always_comb begin
        mem_wb_d.reg_write  = ex_mem_q.reg_write;
        mem_wb_d.result_src = ex_mem_q.result_src;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.read_data  = data_rdata;
        mem_wb_d.pc_plus4   = ex_mem_q.pc_plus4;
        mem_wb_d.rd         = ex_mem_q.rd;
    end

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .rst   (rst),
        .stall (stall_w),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    // write-back
    always_comb begin
        case (mem_wb_q.result_src)
            res_mem:      result_w = mem_wb_q.read_data;
            res_pc_plus4: result_w = mem_wb_q.pc_plus4;
            default:      result_w = mem_wb_q.alu_result;
        endcase
    end

    // stall_w is the memory wait; the held instruction writes once it clears
    assign wb_we = mem_wb_q.reg_write & ~stall_w;

    hazard_unit u_hazard_unit (
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .rs1_e        (id_ex_q.rs1),
        .rs2_e        (id_ex_q.rs2),
        .rd_e         (id_ex_q.rd),
        .mem_read_e   (id_ex_q.mem_read),
        .pc_src       (pc_src),
        .rd_m         (ex_mem_q.rd),
        .reg_write_m  (ex_mem_q.reg_write),
        .rd_w         (mem_wb_q.rd),
        .reg_write_w  (mem_wb_q.reg_write),
        .mem_access_m (ex_mem_q.mem_read | ex_mem_q.mem_write),
        .data_valid   (data_valid),
        .stall_f      (stall_f),
        .stall_d      (stall_d),
        .stall_e      (stall_e),
        .stall_m      (stall_m),
        .stall_w      (stall_w),
        .flush_d      (flush_d),
        .flush_e      (flush_e),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

endmodule

/* tests/tb_riscv_pipeline.sv */
`timescale 1ns/1ps

module tb_riscv_pipeline;
    import rv_pkg::*;

    localparam int n_stores    = 5;
    localparam int store_limit = 200;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] pc;
    logic            instr_en;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] data_addr;
    logic [xlen-1:0] data_wdata;
    logic            data_re;
    logic            data_we;
    logic [xlen-1:0] data_rdata;
    logic            data_valid;

    logic [31:0] rom [32];
    logic [31:0] ram [256];

    // hand-run results of the program in store order
    // alu chain, lui and immediates, load-use sum, jal link, jalr link
    logic [31:0] exp_addr [n_stores] = '{32'h100, 32'h104, 32'h108, 32'h10c, 32'h110};
    logic [31:0] exp_data [n_stores] = '{32'h0000000e, 32'h12345688, 32'hc0de004e,
                                         32'h00000064, 32'h00000074};

    integer      seed = 96792;
    int          delay;
    int          store_idx = 0;
    int          re_rises = 0;
    logic        re_prev = 1'b0;
    logic        pend_valid = 1'b0;
    logic        pend_we;
    logic [31:0] pend_addr;
    logic [31:0] pend_wdata;

    task automatic report_mismatch(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic abort_on_timeout(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_reset_state();
        assert (pc == reset_pc && !data_re && !data_we && instr_en)
        else report_mismatch("core not in its reset state");
    endtask

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // combinational instruction rom
    assign instr = rom[pc[6:2]];

    riscv_pipeline u_riscv_pipeline (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .instr_en   (instr_en),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_re    (data_re),
        .data_we    (data_we),
        .data_rdata (data_rdata),
        .data_valid (data_valid)
    );

    // data ram with 0 to 3 wait cycles per access
    initial begin : data_ram
        logic        done;
        logic        was_access;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        for (int i = 0; i < 256; i++) begin
            ram[i] = 32'hc0de0000 | (i << 2);
        end
        data_valid = 1'b0;
        data_rdata = '0;
        delay = {$random(seed)} % 4;
        forever begin
            @(posedge clk);
            done       = data_valid && (data_re || data_we);
            was_access = data_re || data_we;
            wr         = data_we;
            addr       = data_addr;
            wdata      = data_wdata;
            #1;
            if (done) begin
                if (wr) begin
                    ram[addr[9:2]] = wdata;
                end
                delay = {$random(seed)} % 4;
            end else if (was_access && delay > 0) begin
                delay = delay - 1;
            end
            data_valid = (data_re || data_we) && delay == 0;
            data_rdata = ram[data_addr[9:2]];
        end
    end

    // completed stores checked in order against the table
    always @(posedge clk) begin
        if (!rst && data_we && data_valid) begin
            assert (store_idx < n_stores)
            else report_mismatch("store beyond the end of the expected table");
            assert (data_addr == exp_addr[store_idx] && data_wdata == exp_data[store_idx])
            else report_mismatch($sformatf("store %0d wrote %h to %h", store_idx,
                                           data_wdata, data_addr));
            // third store carries the load-use sum
            if (store_idx == 2) begin
                assert (re_rises == 1)
                else report_mismatch("load strobe did not rise exactly once");
            end
            store_idx = store_idx + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (data_re && !re_prev) begin
                re_rises = re_rises + 1;
            end
            re_prev = data_re;
            assert (re_rises <= 1)
            else report_mismatch("load strobe rose more than once");
        end
    end

    // fetch address stays word aligned, jalr clears bit 0
    always @(posedge clk) begin
        if (!rst) begin
            assert (pc[1:0] == 2'b00)
            else report_mismatch($sformatf("pc %h is not word aligned", pc));
        end
    end

    // a waiting access must not move
    always @(posedge clk) begin
        if (pend_valid) begin
            assert (data_we == pend_we && data_re == !pend_we && data_addr == pend_addr
                    && data_wdata == pend_wdata)
            else report_mismatch("data access changed while waiting for data_valid");
        end
        pend_valid = !rst && (data_re || data_we) && !data_valid;
        pend_we    = data_we;
        pend_addr  = data_addr;
        pend_wdata = data_wdata;
    end

    initial begin : main_seq
        int waited;
        $readmemh("tests/program.hex", rom);
        rst = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_reset_state();
        end
        rst = 1'b0;
        check_reset_state();
        for (int i = 0; i < n_stores; i++) begin
            waited = 0;
            while (store_idx <= i) begin
                @(posedge clk);
                #1;
                waited = waited + 1;
                if (waited > store_limit) begin
                    abort_on_timeout($sformatf("core stopped storing, store %0d never came",
                                               i));
                end
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

/* tests/program.hex */
// one instruction word per line, starting at address 0x00
// hex word, then the address and assembly as a comment
00500093 // 00 addi x1, x0, 5
00708113 // 04 addi x2, x1, 7
401101B3 // 08 sub  x3, x2, x1
0021C233 // 0c xor  x4, x3, x2
002272B3 // 10 and  x5, x4, x2
0012E2B3 // 14 or   x5, x5, x1
0051A333 // 18 slt  x6, x3, x5
00530333 // 1c add  x6, x6, x5
10602023 // 20 sw   x6, 0x100(x0)
123453B7 // 24 lui  x7, 0x12345
6783E393 // 28 ori  x7, x7, 0x678
0FF3C393 // 2c xori x7, x7, 0x0ff
7F03F413 // 30 andi x8, x7, 0x7f0
68142493 // 34 slti x9, x8, 0x681
009383B3 // 38 add  x7, x7, x9
10702223 // 3c sw   x7, 0x104(x0)
04002503 // 40 lw   x10, 0x40(x0)
006505B3 // 44 add  x11, x10, x6
10B02423 // 48 sw   x11, 0x108(x0)
BAD00637 // 4c lui  x12, 0xbad00
00C60663 // 50 beq  x12, x12, +12
1EC02823 // 54 sw   x12, 0x1f0(x0)
1EC02A23 // 58 sw   x12, 0x1f4(x0)
00109463 // 5c bne  x1, x1, +8
008006EF // 60 jal  x13, +8
1EC02C23 // 64 sw   x12, 0x1f8(x0)
10D02623 // 68 sw   x13, 0x10c(x0)
07900713 // 6c addi x14, x0, 0x79
000707E7 // 70 jalr x15, 0(x14)
1EC02E23 // 74 sw   x12, 0x1fc(x0)
10F02823 // 78 sw   x15, 0x110(x0)
0000006F // 7c jal  x0, 0

/* project.f */
design/rv_pkg.sv
design/pipe_reg.sv
design/reg_file.sv
design/decode_stage.sv
design/exec_stage.sv
design/hazard_unit.sv
design/riscv_pipeline.sv
tests/tb_riscv_pipeline.sv
